/* Makefile */
# Verilator build and run for the packed-lane multiplier

VERILATOR ?= verilator
TOP ?= tb_vmul
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/vmul_ref.svh
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_EXE)
	./$(SIM_EXE) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/vmul_ref.svh */
//////////////////////////////////////////////////
// reference lane multiply for the testbench
// typed result compare task
//////////////////////////////////////////////////

`ifndef VMUL_REF_SVH
`define VMUL_REF_SVH

// exact product per lane, then the requested half
function automatic mul_geom_pkg::lane_word_u vmul_ref(
	input mul_ctrl_pkg::sew_e sew,
	input logic sign,
	input logic diff,
	input logic high,
	input mul_geom_pkg::lane_word_u op_1,
	input mul_geom_pkg::lane_word_u op_2
);
	logic [mul_geom_pkg::word_width-1:0] w_1;
	logic [mul_geom_pkg::word_width-1:0] w_2;
	logic [mul_geom_pkg::word_width-1:0] res;
	logic [63:0] mask;
	logic [63:0] prod;
	longint a;
	longint b;
	int width;
	w_1 = op_1;
	w_2 = op_2;
	res = '0;
	case (sew)
		mul_ctrl_pkg::sew_8: width = 8;
		mul_ctrl_pkg::sew_16: width = 16;
		default: width = 32;
	endcase
	mask = (64'd1 << width) - 64'd1;
	for (int l = 0; l < mul_geom_pkg::word_width / width; l++) begin
		a = longint'((w_1 >> (l * width)) & mask);
		b = longint'((w_2 >> (l * width)) & mask);
		if (sign && !diff && a[width-1])
			a = a - longint'(64'd1 << width);
		if (sign && b[width-1])
			b = b - longint'(64'd1 << width);
		prod = a * b;
		if (high)
			prod = prod >> width;
		res = res | 32'((prod & mask) << (l * width));
	end
	return res;
endfunction

// reports every lane that differs, in the view of the given sew
task automatic check_word(
	input string tag,
	input mul_ctrl_pkg::sew_e sew,
	input mul_geom_pkg::lane_word_u got,
	input mul_geom_pkg::lane_word_u exp,
	inout int errors
);
	if (got !== exp) begin
		errors++;
		$display("error result (%s): got %h expected %h", tag, got, exp);
		for (int b = 0; b < mul_geom_pkg::byte_lanes; b++) begin
			if (sew == mul_ctrl_pkg::sew_8 && got.bytes[b] !== exp.bytes[b])
				$display("  byte lane %0d: %h vs %h", b, got.bytes[b], exp.bytes[b]);
		end
		for (int h = 0; h < 2; h++) begin
			if (sew == mul_ctrl_pkg::sew_16 && got.halves[h] !== exp.halves[h])
				$display("  half lane %0d: %h vs %h", h, got.halves[h], exp.halves[h]);
		end
	end
endtask

`endif

/* bench/tb_vmul.sv */
//////////////////////////////////////////////////
// testbench for the packed-lane multiplier
// clock, reset, stimulus, expected queue, checker
//////////////////////////////////////////////////

module tb_vmul;

	`include "vmul_ref.svh"

	localparam int drain_limit = 20;

	logic clk;
	logic rst;
	mul_ctrl_pkg::sew_e sew;
	logic sign;
	logic diff;
	logic high;
	mul_geom_pkg::lane_word_u operand_1;
	mul_geom_pkg::lane_word_u operand_2;
	mul_geom_pkg::lane_word_u result;

	int cycle;
	int errors;
	int timeouts;
	int issued;
	int checks;

	// expected words in issue order, with the cycle each one is due
	mul_geom_pkg::lane_word_u exp_q [$];
	mul_ctrl_pkg::sew_e sew_chk_q [$];
	string tag_q [$];
	int due_q [$];

	vmul_top vmul_top_i (
		.clk(clk),
		.rst(rst),
		.sew(sew),
		.sign(sign),
		.diff(diff),
		.high(high),
		.operand_1(operand_1),
		.operand_2(operand_2),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// sign bit of every lane for this sew
	function automatic logic [31:0] lane_msb_mask(input mul_ctrl_pkg::sew_e s);
		case (s)
			mul_ctrl_pkg::sew_8: return 32'h80808080;
			mul_ctrl_pkg::sew_16: return 32'h80008000;
			default: return 32'h80000000;
		endcase
	endfunction

	// most negative, minus one, zero, one, most positive
	function automatic logic [31:0] corner_word(input int idx, input mul_ctrl_pkg::sew_e s);
		logic [31:0] lane;
		int w;
		w = (s == mul_ctrl_pkg::sew_8) ? 8 : ((s == mul_ctrl_pkg::sew_16) ? 16 : 32);
		case (idx)
			0: lane = 32'd1 << (w - 1);
			1: lane = '1;
			2: lane = '0;
			3: lane = 32'd1;
			default: lane = (32'd1 << (w - 1)) - 32'd1;
		endcase
		case (s)
			mul_ctrl_pkg::sew_8: return {4{lane[7:0]}};
			mul_ctrl_pkg::sew_16: return {2{lane[15:0]}};
			default: return lane;
		endcase
	endfunction

	task automatic apply_op(input string tag, input mul_ctrl_pkg::sew_e s, input logic sg,
		input logic df, input logic hi, input mul_geom_pkg::lane_word_u a,
		input mul_geom_pkg::lane_word_u b);
		@(posedge clk);
		#1;
		sew = s;
		sign = sg;
		diff = df;
		high = hi;
		operand_1 = a;
		operand_2 = b;
		exp_q.push_back(vmul_ref(s, sg, df, hi, a, b));
		sew_chk_q.push_back(s);
		tag_q.push_back(tag);
		// captured at the next edge, registered at the one after
		due_q.push_back(cycle + 2);
		issued++;
	endtask

	task automatic corner_sweep(input string tag, input mul_ctrl_pkg::sew_e s, input logic df);
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				apply_op(tag, s, 1'b1, df, 1'b0, corner_word(i, s), corner_word(j, s));
				apply_op(tag, s, 1'b1, df, 1'b1, corner_word(i, s), corner_word(j, s));
			end
		end
	endtask

	task automatic random_burst(input string tag, input mul_ctrl_pkg::sew_e s, input logic sg,
		input logic df, input logic [31:0] force_1);
		mul_geom_pkg::lane_word_u a;
		mul_geom_pkg::lane_word_u b;
		for (int n = 0; n < 24; n++) begin
			a = $urandom() | force_1;
			b = $urandom();
			apply_op(tag, s, sg, df, n[0], a, b);
		end
	endtask

	// sew, sign, diff and high all change from one cycle to the next
	task automatic mode_shuffle();
		mul_geom_pkg::lane_word_u a;
		mul_geom_pkg::lane_word_u b;
		for (int n = 0; n < 80; n++) begin
			a = $urandom();
			b = $urandom();
			apply_op("back to back", mul_ctrl_pkg::sew_e'($urandom_range(2, 0)),
				1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)),
				1'($urandom_range(1, 0)), a, b);
		end
	endtask

	//////////////////////////////////////////////////
	// checker, samples on the falling edge
	//////////////////////////////////////////////////

	initial begin : compare_results
		mul_geom_pkg::lane_word_u exp_word;
		mul_ctrl_pkg::sew_e exp_sew;
		string tag;
		int due;
		forever begin
			@(negedge clk);
			while (due_q.size() > 0 && due_q[0] <= cycle) begin
				exp_word = exp_q.pop_front();
				exp_sew = sew_chk_q.pop_front();
				tag = tag_q.pop_front();
				due = due_q.pop_front();
				if (due != cycle) begin
					errors++;
					$display("result for %s was not compared in its own cycle", tag);
				end
				else begin
					check_word(tag, exp_sew, result, exp_word, errors);
				end
				checks++;
			end
		end
	end

	initial begin : main_sequence
		int wait_count;
		void'($urandom(32'hed5ce06c));
		cycle = 0;
		errors = 0;
		timeouts = 0;
		issued = 0;
		checks = 0;
		rst = 1'b1;
		sew = mul_ctrl_pkg::sew_8;
		sign = 1'b0;
		diff = 1'b0;
		high = 1'b0;
		operand_1 = '0;
		operand_2 = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		@(negedge clk);
		check_word("after reset", mul_ctrl_pkg::sew_32, result, '0, errors);

		for (int k = 0; k < 3; k++) begin
			random_burst("unsigned", mul_ctrl_pkg::sew_e'(k), 1'b0, 1'b0, '0);
		end
		for (int k = 0; k < 3; k++) begin
			corner_sweep("signed corner", mul_ctrl_pkg::sew_e'(k), 1'b0);
			random_burst("signed", mul_ctrl_pkg::sew_e'(k), 1'b1, 1'b0, '0);
		end
		for (int k = 0; k < 3; k++) begin
			corner_sweep("mixed corner", mul_ctrl_pkg::sew_e'(k), 1'b1);
			random_burst("mixed", mul_ctrl_pkg::sew_e'(k), 1'b1, 1'b1, '0);
			// operand_1 top bit set in every lane
			random_burst("mixed top bit", mul_ctrl_pkg::sew_e'(k), 1'b1, 1'b1,
				lane_msb_mask(mul_ctrl_pkg::sew_e'(k)));
		end
		mode_shuffle();

		for (wait_count = 0; wait_count < drain_limit && due_q.size() > 0; wait_count++) begin
			@(posedge clk);
		end
		if (due_q.size() > 0) begin
			timeouts++;
			$display("timeout: %0d results still pending after %0d cycles", due_q.size(),
				drain_limit);
		end
		if (checks != issued) begin
			errors++;
			$display("only %0d of %0d issued operations were checked", checks, issued);
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* hdl/carry_save_reduce.sv */
//////////////////////////////////////////////////
// partial product alignment per element width
// 4:2 carry-save tree down to sum and carry
//////////////////////////////////////////////////

module carry_save_reduce (
	input mul_geom_pkg::pp_array_t products,
	input mul_ctrl_pkg::sew_e sew,
	output mul_geom_pkg::product_vec_t sum,
	output mul_geom_pkg::product_vec_t carry
);

	mul_geom_pkg::product_vec_t aligned [mul_geom_pkg::byte_lanes*mul_geom_pkg::byte_lanes];
	mul_geom_pkg::product_vec_t row_1 [8];
	mul_geom_pkg::product_vec_t row_2 [4];

	// both bytes inside the same element for this sew
	function automatic logic same_lane(input int i, input int j, input mul_ctrl_pkg::sew_e s);
		case (s)
			mul_ctrl_pkg::sew_8: return i == j;
			mul_ctrl_pkg::sew_16: return (i / 2) == (j / 2);
			default: return 1'b1;
		endcase
	endfunction

	// two 3:2 layers, four rows in and two rows out
	function automatic void csa_4_2(
		input mul_geom_pkg::product_vec_t a,
		input mul_geom_pkg::product_vec_t b,
		input mul_geom_pkg::product_vec_t c,
		input mul_geom_pkg::product_vec_t d,
		output mul_geom_pkg::product_vec_t s,
		output mul_geom_pkg::product_vec_t co
	);
		mul_geom_pkg::product_vec_t s_1;
		mul_geom_pkg::product_vec_t c_1;
		s_1 = a ^ b ^ c;
		c_1 = ((a & b) | (a & c) | (b & c)) << 1;
		s = s_1 ^ c_1 ^ d;
		co = ((s_1 & c_1) | (s_1 & d) | (c_1 & d)) << 1;
	endfunction

	genvar i, j;
	generate
		for (i = 0; i < mul_geom_pkg::byte_lanes; i++) begin : g_row
			for (j = 0; j < mul_geom_pkg::byte_lanes; j++) begin : g_col
				// lane base (2x lane width) plus 8x the byte offsets is just 8*(i+j)
				assign aligned[mul_geom_pkg::byte_lanes*i+j] = same_lane(i, j, sew) ?
					mul_geom_pkg::product_vec_t'(products[i][j]) << (8 * (i + j)) : '0;
			end
		end
	endgenerate

	//////////////////////////////////////////////////
	// 16 -> 8 -> 4 -> 2
	//////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			csa_4_2(aligned[4*k], aligned[4*k+1], aligned[4*k+2], aligned[4*k+3],
				row_1[2*k], row_1[2*k+1]);
		end
		for (int k = 0; k < 2; k++) begin
			csa_4_2(row_1[4*k], row_1[4*k+1], row_1[4*k+2], row_1[4*k+3],
				row_2[2*k], row_2[2*k+1]);
		end
		csa_4_2(row_2[0], row_2[1], row_2[2], row_2[3], sum, carry);
	end

endmodule

/* hdl/carry_select_adder.sv */
//////////////////////////////////////////////////
// 64 bit carry-select adder
// 8 bit blocks, both carry-in versions above block 0
//////////////////////////////////////////////////

module carry_select_adder (
	input mul_geom_pkg::product_vec_t operand_1,
	input mul_geom_pkg::product_vec_t operand_2,
	output mul_geom_pkg::product_vec_t result
);

	logic [8:0] sum_c0 [mul_geom_pkg::product_width/8];
	logic [8:0] sum_c1 [mul_geom_pkg::product_width/8-1:1];
	logic [mul_geom_pkg::product_width/8:0] carry;

	// adder carry-in is tied low
	assign carry[0] = 1'b0;

	genvar b;
	generate
		for (b = 0; b < mul_geom_pkg::product_width / 8; b++) begin : g_block
			assign sum_c0[b] = {1'b0, operand_1[8*b +: 8]} + {1'b0, operand_2[8*b +: 8]};
			if (b == 0) begin : g_low
				assign {carry[1], result[7:0]} = sum_c0[0];
			end
			else begin : g_sel
				assign sum_c1[b] = {1'b0, operand_1[8*b +: 8]} +
					{1'b0, operand_2[8*b +: 8]} + 9'd1;
				// chosen carry of the block below picks the version
				assign {carry[b+1], result[8*b +: 8]} = carry[b] ? sum_c1[b] : sum_c0[b];
			end
		end
	endgenerate

endmodule

/* hdl/lane_result_select.sv */
//////////////////////////////////////////////////
// per-lane negation and half select
// output register of the multiplier
//////////////////////////////////////////////////

module lane_result_select (
	input logic clk,
	input logic rst,
	input mul_geom_pkg::product_vec_t full,
	input mul_ctrl_pkg::sew_e sew,
	input logic high,
	input mul_ctrl_pkg::lane_flags_t negate,
	output mul_geom_pkg::lane_word_u result
);

	logic [mul_geom_pkg::byte_lanes-1:0][15:0] lane_16;
	logic [mul_geom_pkg::byte_lanes/2-1:0][31:0] lane_32;
	mul_geom_pkg::product_vec_t lane_64;
	mul_geom_pkg::lane_word_u next_word;

	// each product lane is negated on its own, no borrow crosses a lane
	always_comb begin
		lane_16 = full;
		lane_32 = full;
		lane_64 = full;
		for (int b = 0; b < mul_geom_pkg::byte_lanes; b++) begin
			if (negate[b])
				lane_16[b] = ~full[16*b +: 16] + 16'd1;
		end
		for (int h = 0; h < mul_geom_pkg::byte_lanes / 2; h++) begin
			if (negate[2*h])
				lane_32[h] = ~full[32*h +: 32] + 32'd1;
		end
		if (negate[0])
			lane_64 = ~full + 64'd1;
	end

	always_comb begin
		next_word = '0;
		case (sew)
			mul_ctrl_pkg::sew_8: begin
				for (int b = 0; b < mul_geom_pkg::byte_lanes; b++) begin
					next_word.bytes[b] = high ? lane_16[b][15:8] : lane_16[b][7:0];
				end
			end
			mul_ctrl_pkg::sew_16: begin
				for (int h = 0; h < mul_geom_pkg::byte_lanes / 2; h++) begin
					next_word.halves[h] = high ? lane_32[h][31:16] : lane_32[h][15:0];
				end
			end
			mul_ctrl_pkg::sew_32: next_word = high ? lane_64[63:32] : lane_64[31:0];
			default: next_word = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			result <= '0;
		else
			result <= next_word;
	end

	// flags were replicated in operand conditioning two stages back
	a_flags_16: assert property (@(posedge clk) disable iff (rst)
		(sew == mul_ctrl_pkg::sew_16) |-> (negate[0] == negate[1]) && (negate[2] == negate[3]));
	a_flags_32: assert property (@(posedge clk) disable iff (rst)
		(sew == mul_ctrl_pkg::sew_32) |-> (negate == '0) || (negate == '1));

endmodule

/* hdl/mul_ctrl_pkg.sv */
//////////////////////////////////////////////////
// multiplier control
// element width encoding and per-lane flag type
//////////////////////////////////////////////////

package mul_ctrl_pkg;

	localparam int sew_bits = 2;

	// code 2'b11 is not a legal element width
	typedef enum logic [sew_bits-1:0] {
		sew_8 = 2'b00,
		sew_16 = 2'b01,
		sew_32 = 2'b10
	} sew_e;

	// one flag per byte lane
	// a 16 or 32 bit lane repeats its flag in every byte
	typedef logic [mul_geom_pkg::byte_lanes-1:0] lane_flags_t;

endpackage

/* hdl/mul_geom_pkg.sv */
//////////////////////////////////////////////////
// multiplier geometry
// word, lane and product widths
// lane word union, product and partial product types
//////////////////////////////////////////////////

package mul_geom_pkg;

	localparam int word_width = 32;
	localparam int byte_lanes = 4;
	localparam int product_width = 64;

	// one operand or result word, seen as bytes for sew 8
	// and as halfwords for sew 16
	typedef union packed {
		logic [byte_lanes-1:0][7:0] bytes;
		logic [word_width/16-1:0][15:0] halves;
	} lane_word_u;

	// double width vector, also used for carry-save rows
	typedef logic [product_width-1:0] product_vec_t;

	// [operand_1 byte][operand_2 byte]
	typedef logic [byte_lanes-1:0][byte_lanes-1:0][15:0] pp_array_t;

endpackage

/* hdl/mul_operand_if.sv */
//////////////////////////////////////////////////
// conditioned operands and lane control
// from operand conditioning to the product array
//////////////////////////////////////////////////

interface mul_operand_if (
	input logic clk,
	input logic rst
);

	mul_geom_pkg::lane_word_u mag_1;
	mul_geom_pkg::lane_word_u mag_2;
	mul_ctrl_pkg::sew_e sew;
	logic high;
	mul_ctrl_pkg::lane_flags_t lane_negate;

	modport src (
		input clk,
		input rst,
		output mag_1,
		output mag_2,
		output sew,
		output high,
		output lane_negate
	);

	modport dst (input mag_1, input mag_2, input sew, input high, input lane_negate);

endinterface

/* hdl/operand_condition.sv */
//////////////////////////////////////////////////
// operand conditioning
// per-lane magnitudes and result negate flags
//////////////////////////////////////////////////

module operand_condition (
	input mul_ctrl_pkg::sew_e sew,
	input logic sign,
	input logic diff,
	input logic high,
	input mul_geom_pkg::lane_word_u operand_1,
	input mul_geom_pkg::lane_word_u operand_2,
	mul_operand_if.src ops
);

	logic neg_1_en;
	logic neg_2_en;

	// product sign of one lane from the two operand sign bits
	function automatic logic lane_flip(input logic sgn, input logic mix, input logic s_1,
		input logic s_2);
		return sgn & (mix ? s_2 : (s_1 ^ s_2));
	endfunction

	// operand_1 is treated unsigned in mixed mode
	assign neg_1_en = sign & ~diff;
	assign neg_2_en = sign;

	assign ops.sew = sew;
	assign ops.high = high;

	always_comb begin
		ops.mag_1 = operand_1;
		ops.mag_2 = operand_2;
		ops.lane_negate = '0;
		case (sew)
			mul_ctrl_pkg::sew_8: begin
				for (int b = 0; b < mul_geom_pkg::byte_lanes; b++) begin
					if (neg_1_en && operand_1.bytes[b][7])
						ops.mag_1.bytes[b] = ~operand_1.bytes[b] + 8'd1;
					if (neg_2_en && operand_2.bytes[b][7])
						ops.mag_2.bytes[b] = ~operand_2.bytes[b] + 8'd1;
					ops.lane_negate[b] = lane_flip(sign, diff, operand_1.bytes[b][7],
						operand_2.bytes[b][7]);
				end
			end
			mul_ctrl_pkg::sew_16: begin
				for (int h = 0; h < 2; h++) begin
					if (neg_1_en && operand_1.halves[h][15])
						ops.mag_1.halves[h] = ~operand_1.halves[h] + 16'd1;
					if (neg_2_en && operand_2.halves[h][15])
						ops.mag_2.halves[h] = ~operand_2.halves[h] + 16'd1;
					ops.lane_negate[2*h +: 2] = {2{lane_flip(sign, diff,
						operand_1.halves[h][15], operand_2.halves[h][15])}};
				end
			end
			mul_ctrl_pkg::sew_32: begin
				if (neg_1_en && operand_1.halves[1][15])
					ops.mag_1 = ~operand_1 + 32'd1;
				if (neg_2_en && operand_2.halves[1][15])
					ops.mag_2 = ~operand_2 + 32'd1;
				ops.lane_negate = {mul_geom_pkg::byte_lanes{lane_flip(sign, diff,
					operand_1.halves[1][15], operand_2.halves[1][15])}};
			end
			default: ops.lane_negate = '0;
		endcase
	end

	a_sew_legal: assert property (@(posedge ops.clk) disable iff (ops.rst)
		sew inside {mul_ctrl_pkg::sew_8, mul_ctrl_pkg::sew_16, mul_ctrl_pkg::sew_32});

endmodule

/* hdl/partial_product_array.sv */
//////////////////////////////////////////////////
// 8x8 partial product array
// first pipeline stage with aligned control
//////////////////////////////////////////////////

module partial_product_array (
	input logic clk,
	input logic rst,
	mul_operand_if.dst ops,
	output mul_geom_pkg::pp_array_t products,
	output mul_ctrl_pkg::sew_e sew_q,
	output logic high_q,
	output mul_ctrl_pkg::lane_flags_t negate_q
);

	mul_geom_pkg::pp_array_t products_d;

	// every byte of mag_1 times every byte of mag_2
	// cross-lane products are dropped later in the reduction
	always_comb begin
		for (int i = 0; i < mul_geom_pkg::byte_lanes; i++) begin
			for (int j = 0; j < mul_geom_pkg::byte_lanes; j++) begin
				products_d[i][j] = 16'(ops.mag_1.bytes[i]) * 16'(ops.mag_2.bytes[j]);
			end
		end
	end

	//////////////////////////////////////////////////
	// stage 1 register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			products <= '0;
			sew_q <= mul_ctrl_pkg::sew_8;
			high_q <= 1'b0;
			negate_q <= '0;
		end
		else begin
			products <= products_d;
			sew_q <= ops.sew;
			high_q <= ops.high;
			negate_q <= ops.lane_negate;
		end
	end

endmodule

/* hdl/vmul_top.sv */
//////////////////////////////////////////////////
// packed-lane integer multiplier, top level
// two register stages, one operation per cycle
//////////////////////////////////////////////////

module vmul_top (
	input logic clk,
	input logic rst,
	input mul_ctrl_pkg::sew_e sew,
	input logic sign,
	input logic diff,
	input logic high,
	input mul_geom_pkg::lane_word_u operand_1,
	input mul_geom_pkg::lane_word_u operand_2,
	output mul_geom_pkg::lane_word_u result
);

	mul_geom_pkg::pp_array_t products;
	mul_ctrl_pkg::sew_e sew_q;
	logic high_q;
	mul_ctrl_pkg::lane_flags_t negate_q;
	mul_geom_pkg::product_vec_t csa_sum;
	mul_geom_pkg::product_vec_t csa_carry;
	mul_geom_pkg::product_vec_t full_sum;

	mul_operand_if ops_if (.clk(clk), .rst(rst));

	operand_condition operand_condition_i (
		.sew(sew),
		.sign(sign),
		.diff(diff),
		.high(high),
		.operand_1(operand_1),
		.operand_2(operand_2),
		.ops(ops_if)
	);

	partial_product_array partial_product_array_i (
		.clk(clk),
		.rst(rst),
		.ops(ops_if),
		.products(products),
		.sew_q(sew_q),
		.high_q(high_q),
		.negate_q(negate_q)
	);

	carry_save_reduce carry_save_reduce_i (
		.products(products),
		.sew(sew_q),
		.sum(csa_sum),
		.carry(csa_carry)
	);

	carry_select_adder carry_select_adder_i (
		.operand_1(csa_sum),
		.operand_2(csa_carry),
		.result(full_sum)
	);

	lane_result_select lane_result_select_i (
		.clk(clk),
		.rst(rst),
		.full(full_sum),
		.sew(sew_q),
		.high(high_q),
		.negate(negate_q),
		.result(result)
	);

endmodule

/* sim.f */
+incdir+include
hdl/mul_geom_pkg.sv
hdl/mul_ctrl_pkg.sv
hdl/mul_operand_if.sv
hdl/operand_condition.sv
hdl/partial_product_array.sv
hdl/carry_save_reduce.sv
hdl/carry_select_adder.sv
hdl/lane_result_select.sv
hdl/vmul_top.sv
bench/tb_vmul.sv
